//--- hw/bi_pkg.sv
package bi_pkg;

    // user word, split into equal segments
    localparam int DATA_W = 32;
    localparam int NUM_SEG = 4;
    localparam int SEG_W = DATA_W / NUM_SEG;

    // coded bits plus one invert flag per segment
    localparam int LINK_W = DATA_W + NUM_SEG;

    // popcount of one segment, 0..SEG_W
    localparam int SEG_CNT_W = $clog2(SEG_W + 1);

    // a coded segment and its flag toggle at most SEG_W/2+1 wires
    // bins run from 0 up to NUM_SEG times that
    localparam int HIST_BINS = NUM_SEG * (SEG_W / 2 + 1) + 1;
    localparam int BIN_W = $clog2(HIST_BINS);
    localparam int HIST_CNT_W = 16;

    // weighted sum of all bins
    localparam int SUM_W = 22;

    // word on the physical link
    typedef struct packed {
        // coded payload, segment 0 in the low bits
        logic [DATA_W-1:0]  data;
        // one flag per segment, set when that segment went out inverted
        logic [NUM_SEG-1:0] inv;
    } link_word_t;

    // statistics scan FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_DONE
    } stats_state_t;

endpackage

//--- hw/bi_tx_stage.sv
module bi_tx_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [bi_pkg::DATA_W-1:0] in_data_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    input  logic                      tx_ready_i,
    output logic [bi_pkg::DATA_W-1:0] tx_data_o,
    output logic                      tx_valid_o,
    output logic                      advance_o
);
    import bi_pkg::*;

    logic [DATA_W-1:0] data_q;
    logic              full_q;
    logic              accept;

    // word moves on into the link register this cycle
    assign advance_o = full_q & tx_ready_i;

    // room when empty or when the held word leaves now
    assign in_ready_o = ~full_q | tx_ready_i;
    assign accept = in_valid_i & in_ready_o;

    // occupancy flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (advance_o) begin
            full_q <= 1'b0;
        end
    end

    // payload, only written on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= in_data_i;
        end
    end

    // segments go to the coders straight from the register
    assign tx_data_o = data_q;
    assign tx_valid_o = full_q;

endmodule

//--- hw/bi_seg_coder.sv
module bi_seg_coder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [bi_pkg::SEG_W-1:0] seg_i,
    input  logic                     advance_i,
    output logic [bi_pkg::SEG_W-1:0] seg_o,
    output logic                     inv_o
);
    import bi_pkg::*;

    // last coded value seen on the wires of this segment
    logic [SEG_W-1:0]     prev_seg_q;
    logic                 prev_inv_q;
    logic [SEG_W-1:0]     seg_diff;
    logic [SEG_CNT_W-1:0] diff_cnt;
    logic                 more_than_half;
    logic                 exactly_half;

    // wires that would toggle if sent as is
    assign seg_diff = seg_i ^ prev_seg_q;

    // popcount
    always_comb begin
        diff_cnt = '0;
        for (int b = 0; b < SEG_W; b++) begin
            diff_cnt = diff_cnt + SEG_CNT_W'(seg_diff[b]);
        end
    end

    assign more_than_half = diff_cnt > SEG_CNT_W'(SEG_W / 2);
    assign exactly_half = diff_cnt == SEG_CNT_W'(SEG_W / 2);

    // on a tie keep the old flag, so the flag wire itself stays quiet
    assign inv_o = more_than_half | (exactly_half & prev_inv_q);
    assign seg_o = inv_o ? ~seg_i : seg_i;

    // history only moves when the word really goes onto the link
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_seg_q <= '0;
            prev_inv_q <= 1'b0;
        end else if (advance_i) begin
            prev_seg_q <= seg_o;
            prev_inv_q <= inv_o;
        end
    end

endmodule

//--- hw/bi_link_reg.sv
module bi_link_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tx_valid_i,
    input  bi_pkg::link_word_t code_i,
    output logic               tx_ready_o,
    input  logic               link_ready_i,
    output bi_pkg::link_word_t link_o,
    output logic               link_valid_o,
    output logic               link_load_o
);
    import bi_pkg::*;

    // wires of the link, zero until the first word
    link_word_t link_q;
    logic       full_q;
    logic       load_q;
    logic       load;

    // free when empty or when the receive side takes the word now
    assign tx_ready_o = ~full_q | link_ready_i;
    assign load = tx_valid_i & tx_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_q <= '0;
            full_q <= 1'b0;
            load_q <= 1'b0;
        end else begin
            // strobe lines up with the new word on the wires
            load_q <= load;
            if (load) begin
                link_q <= code_i;
                full_q <= 1'b1;
            end else if (link_ready_i) begin
                // word consumed, wires keep their last value
                full_q <= 1'b0;
            end
        end
    end

    assign link_o = link_q;
    assign link_valid_o = full_q;
    assign link_load_o = load_q;

endmodule

//--- hw/bi_rx_stage.sv
module bi_rx_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  bi_pkg::link_word_t        link_i,
    input  logic                      link_valid_i,
    output logic                      link_ready_o,
    output logic [bi_pkg::DATA_W-1:0] out_data_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i
);
    import bi_pkg::*;

    logic [DATA_W-1:0] restored;
    logic [DATA_W-1:0] data_q;
    logic              full_q;
    logic              load;

    // undo the inversion segment by segment
    always_comb begin
        restored = link_i.data;
        for (int s = 0; s < NUM_SEG; s++) begin
            if (link_i.inv[s]) begin
                restored[s*SEG_W +: SEG_W] = ~link_i.data[s*SEG_W +: SEG_W];
            end
        end
    end

    // ready when empty or when the consumer takes the word now
    assign link_ready_o = ~full_q | out_ready_i;
    assign load = link_valid_i & link_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0;
        end
    end

    // restored word, held steady while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= restored;
        end
    end

    assign out_data_o = data_q;
    assign out_valid_o = full_q;

endmodule

//--- hw/bi_transition_stats.sv
module bi_transition_stats (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bi_pkg::link_word_t       link_i,
    input  logic                     link_load_i,
    input  logic                     stat_req_i,
    output logic                     stat_valid_o,
    output logic [bi_pkg::BIN_W-1:0] stat_bin_o,
    output logic [bi_pkg::SUM_W-1:0] stat_sum_o
);
    import bi_pkg::*;

    // last loaded link word, zero after reset
    link_word_t                  prev_link_q;
    logic [LINK_W-1:0]           link_diff;
    logic [$clog2(LINK_W+1)-1:0] diff_cnt;
    logic [BIN_W-1:0]            hit_bin;
    logic [HIST_CNT_W-1:0]       hist_q [HIST_BINS];

    stats_state_t     state_q;
    logic [BIN_W-1:0] scan_idx_q;
    logic             req_accept;
    logic             stat_valid_q;

    // scan accumulators and results
    logic [HIST_CNT_W-1:0] run_max_q;
    logic [BIN_W-1:0]      run_bin_q;
    logic [SUM_W-1:0]      run_sum_q;
    logic [SUM_W-1:0]      weighted;
    logic [BIN_W-1:0]      stat_bin_q;
    logic [SUM_W-1:0]      stat_sum_q;

    // toggled wires, flags included
    assign link_diff = link_i ^ prev_link_q;

    always_comb begin
        diff_cnt = '0;
        for (int b = 0; b < LINK_W; b++) begin
            diff_cnt = diff_cnt + ($bits(diff_cnt))'(link_diff[b]);
        end
    end

    // clamp to the top bin, unreachable with correct coding
    assign hit_bin = (diff_cnt >= ($bits(diff_cnt))'(HIST_BINS)) ?
                     BIN_W'(HIST_BINS - 1) : BIN_W'(diff_cnt);

    // histogram keeps counting during a scan
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_link_q <= '0;
            for (int i = 0; i < HIST_BINS; i++) begin
                hist_q[i] <= '0;
            end
        end else if (link_load_i) begin
            prev_link_q <= link_i;
            hist_q[hit_bin] <= hist_q[hit_bin] + 1'b1;
        end
    end

    // requests are dropped while a scan is running
    assign req_accept = (state_q == ST_IDLE) & stat_req_i;

    // scan FSM, one bin per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            scan_idx_q <= '0;
            stat_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_accept) begin
                        state_q <= ST_SCAN;
                        scan_idx_q <= '0;
                        stat_valid_q <= 1'b0;
                    end
                end
                ST_SCAN: begin
                    scan_idx_q <= scan_idx_q + 1'b1;
                    // last bin handled this cycle
                    if (scan_idx_q == BIN_W'(HIST_BINS - 1)) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state_q <= ST_IDLE;
                    stat_valid_q <= 1'b1;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // bin index times its count
    assign weighted = SUM_W'(scan_idx_q) * SUM_W'(hist_q[scan_idx_q]);

    always_ff @(posedge clk) begin
        if (req_accept) begin
            run_max_q <= '0;
            run_bin_q <= '0;
            run_sum_q <= '0;
        end else if (state_q == ST_SCAN) begin
            // strictly greater, so ties stay on the lower bin
            if (hist_q[scan_idx_q] > run_max_q) begin
                run_max_q <= hist_q[scan_idx_q];
                run_bin_q <= scan_idx_q;
            end
            run_sum_q <= run_sum_q + weighted;
        end
        // results latched together with the valid flag
        if (state_q == ST_DONE) begin
            stat_bin_q <= run_bin_q;
            stat_sum_q <= run_sum_q;
        end
    end

    assign stat_valid_o = stat_valid_q;
    assign stat_bin_o = stat_bin_q;
    assign stat_sum_o = stat_sum_q;

endmodule

//--- hw/bi_link_top.sv
module bi_link_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // input port
    input  logic [bi_pkg::DATA_W-1:0] in_data_i,
    input  logic                      in_valid_i,
    output logic                      in_ready_o,
    // output port
    output logic [bi_pkg::DATA_W-1:0] out_data_o,
    output logic                      out_valid_o,
    input  logic                      out_ready_i,
    // physical link wires
    output bi_pkg::link_word_t        link_o,
    // statistics
    input  logic                      stat_req_i,
    output logic                      stat_valid_o,
    output logic [bi_pkg::BIN_W-1:0]  stat_bin_o,
    output logic [bi_pkg::SUM_W-1:0]  stat_sum_o
);

    // tx stage to coders and link register
    logic [bi_pkg::DATA_W-1:0] tx_data;
    logic                      tx_valid;
    logic                      tx_ready;
    logic                      advance;

    // coder outputs, one slice per segment
    wire [bi_pkg::DATA_W-1:0]  code_data;
    wire [bi_pkg::NUM_SEG-1:0] code_inv;
    bi_pkg::link_word_t        code_word;

    // link register to receive side and statistics
    bi_pkg::link_word_t link_word;
    logic               link_valid;
    logic               link_ready;
    logic               link_load;

    bi_tx_stage u_tx_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data_i  (in_data_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .tx_ready_i (tx_ready),
        .tx_data_o  (tx_data),
        .tx_valid_o (tx_valid),
        .advance_o  (advance)
    );

    // identical coder per segment, each with its own history
    for (genvar g = 0; g < bi_pkg::NUM_SEG; g++) begin : gen_seg_coder
        bi_seg_coder u_seg_coder (
            .clk       (clk),
            .rst_n     (rst_n),
            .seg_i     (tx_data[g*bi_pkg::SEG_W +: bi_pkg::SEG_W]),
            .advance_i (advance),
            .seg_o     (code_data[g*bi_pkg::SEG_W +: bi_pkg::SEG_W]),
            .inv_o     (code_inv[g])
        );
    end

    assign code_word = '{data: code_data, inv: code_inv};

    bi_link_reg u_link_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_valid_i   (tx_valid),
        .code_i       (code_word),
        .tx_ready_o   (tx_ready),
        .link_ready_i (link_ready),
        .link_o       (link_word),
        .link_valid_o (link_valid),
        .link_load_o  (link_load)
    );

    assign link_o = link_word;

    bi_rx_stage u_rx_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .link_i       (link_word),
        .link_valid_i (link_valid),
        .link_ready_o (link_ready),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

    // watches the wires, not the handshake
    bi_transition_stats u_stats (
        .clk          (clk),
        .rst_n        (rst_n),
        .link_i       (link_word),
        .link_load_i  (link_load),
        .stat_req_i   (stat_req_i),
        .stat_valid_o (stat_valid_o),
        .stat_bin_o   (stat_bin_o),
        .stat_sum_o   (stat_sum_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // period 100
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb/bi_link_tb.sv
module bi_link_tb;
    import bi_pkg::*;

    localparam int NUM_WORDS = 200;
    localparam int NUM_TIE = 8;
    // every word takes at most four cycles, plus two scans, reset and slack
    localparam int CYCLE_LIMIT = (2 * NUM_WORDS + NUM_TIE) * 4 + 2 * (HIST_BINS + 2)
                                 + 8 + 200;

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] in_data_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [DATA_W-1:0] out_data_o;
    logic              out_valid_o;
    logic              out_ready_i;
    link_word_t        link_o;
    logic              stat_req_i;
    logic              stat_valid_o;
    logic [BIN_W-1:0]  stat_bin_o;
    logic [SUM_W-1:0]  stat_sum_o;

    integer seed;
    int     cyc;
    int     checks;
    int     errors;
    logic   lat_mode;
    logic   bp_mode;

    // software model of the coders and the histogram
    logic [SEG_W-1:0] m_prev_seg [NUM_SEG];
    logic             m_prev_inv [NUM_SEG];
    link_word_t       m_prev_link;
    link_word_t       obs_prev_link;
    int               m_hist [HIST_BINS];
    int               tie_set;
    int               tie_clr;

    // words in flight
    link_word_t        exp_link_q [$];
    logic [DATA_W-1:0] exp_data_q [$];
    int                acc_edge_q [$];
    int                acc_cnt;
    int                out_cnt;

    // output stall tracking
    logic              prev_stall;
    logic [DATA_W-1:0] held_data;

    // statistics timing
    int   req_edge;
    int   rise_edge;
    logic prev_stat_valid;
    logic stat_seen;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bi_link_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_data_i    (in_data_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .out_data_o   (out_data_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .link_o       (link_o),
        .stat_req_i   (stat_req_i),
        .stat_valid_o (stat_valid_o),
        .stat_bin_o   (stat_bin_o),
        .stat_sum_o   (stat_sum_o)
    );

    function automatic int popcount(logic [LINK_W-1:0] v);
        int n;
        n = 0;
        for (int b = 0; b < LINK_W; b++) begin
            n += int'(v[b]);
        end
        return n;
    endfunction

    // invert rule per segment, history moves with every accepted word
    function automatic link_word_t code_and_commit(logic [DATA_W-1:0] w);
        link_word_t       lw;
        logic [SEG_W-1:0] seg;
        int               d;
        logic             inv;
        for (int s = 0; s < NUM_SEG; s++) begin
            seg = w[s*SEG_W +: SEG_W];
            d = popcount(LINK_W'(seg ^ m_prev_seg[s]));
            if (d == SEG_W / 2) begin
                if (m_prev_inv[s]) tie_set++;
                else tie_clr++;
            end
            inv = (d > SEG_W / 2) || (d == SEG_W / 2 && m_prev_inv[s]);
            lw.data[s*SEG_W +: SEG_W] = inv ? ~seg : seg;
            lw.inv[s] = inv;
            m_prev_seg[s] = lw.data[s*SEG_W +: SEG_W];
            m_prev_inv[s] = inv;
        end
        return lw;
    endfunction

    task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // monitor, sampled on the rising edge before the registers move
    always @(posedge clk) begin
        link_word_t exp_lw;
        int         seg_moves;
        int         bin;
        cyc++;
        if (cyc > CYCLE_LIMIT) begin
            $display("run stopped by timeout after %0d cycles", cyc);
            $display("Test failures found");
            $finish;
        end else if (rst_n) begin
            // back pressure rule, judged before this edge counts anything
            check_true(acc_cnt - out_cnt <= 3, "more than three words held in the pipeline");
            if (acc_cnt - out_cnt == 3 && !out_ready_i) begin
                check_eq("back_pressure in_ready", 0, in_ready_o);
            end
            if (prev_stall) begin
                check_eq("back_pressure valid", 1, out_valid_o);
                check_eq("back_pressure hold", held_data, out_data_o);
            end
            prev_stall = out_valid_o && !out_ready_i;
            held_data = out_data_o;

            if (in_valid_i && in_ready_o) begin
                exp_link_q.push_back(code_and_commit(in_data_i));
                exp_data_q.push_back(in_data_i);
                acc_edge_q.push_back(cyc);
                acc_cnt++;
            end

            // link word loaded at the previous edge
            if (dut.link_load) begin
                if (exp_link_q.size() == 0) begin
                    check_true(1'b0, "link loaded a word that was never sent");
                end else begin
                    exp_lw = exp_link_q.pop_front();
                    check_eq("link_coding", exp_lw, link_o);
                    for (int s = 0; s < NUM_SEG; s++) begin
                        seg_moves = popcount(LINK_W'(link_o.data[s*SEG_W +: SEG_W] ^
                                                     obs_prev_link.data[s*SEG_W +: SEG_W]));
                        seg_moves += int'(link_o.inv[s] ^ obs_prev_link.inv[s]);
                        check_true(seg_moves <= SEG_W / 2 + 1,
                                   "a segment toggled more wires than bus invert allows");
                    end
                    obs_prev_link = link_o;
                    bin = popcount(exp_lw ^ m_prev_link);
                    if (bin > HIST_BINS - 1) bin = HIST_BINS - 1;
                    m_hist[bin]++;
                    m_prev_link = exp_lw;
                end
            end

            if (out_valid_o && out_ready_i) begin
                if (exp_data_q.size() == 0) begin
                    check_true(1'b0, "output delivered a word that was never sent");
                end else begin
                    check_eq("round_trip", exp_data_q.pop_front(), out_data_o);
                    if (lat_mode) begin
                        check_eq("latency", 3, cyc - acc_edge_q[0]);
                    end
                    void'(acc_edge_q.pop_front());
                    out_cnt++;
                end
            end

            if (stat_req_i) req_edge = cyc;
            // visible before this edge, so it rose at the one before
            if (stat_valid_o && !prev_stat_valid) begin
                rise_edge = cyc - 1;
                stat_seen = 1'b1;
            end
            prev_stat_valid = stat_valid_o;
        end
    end

    // random stalls on the consumer side
    always @(negedge clk) begin
        if (bp_mode) out_ready_i <= ($random(seed) % 3) != 0;
        else out_ready_i <= 1'b1;
    end

    task automatic send_word(logic [DATA_W-1:0] w);
        logic taken;
        in_data_i = w;
        in_valid_i = 1'b1;
        do begin
            @(posedge clk);
            taken = in_ready_o;
            @(negedge clk);
        end while (!taken);
    endtask

    task automatic drain;
        in_valid_i = 1'b0;
        while (out_cnt != acc_cnt) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // each pass drives every segment to a chosen distance from its history
    task automatic send_ties;
        logic [SEG_W-1:0]  pat [4];
        logic [DATA_W-1:0] w;
        pat[0] = 8'hff;
        pat[1] = 8'h0f;
        pat[2] = 8'h00;
        pat[3] = 8'hf0;
        for (int k = 0; k < NUM_TIE; k++) begin
            for (int s = 0; s < NUM_SEG; s++) begin
                w[s*SEG_W +: SEG_W] = m_prev_seg[s] ^ pat[k % 4];
            end
            send_word(w);
        end
    endtask

    // one request, then compare against the model histogram
    task automatic request_stats;
        int exp_bin;
        int exp_max;
        int exp_sum;
        stat_seen = 1'b0;
        stat_req_i = 1'b1;
        @(negedge clk);
        stat_req_i = 1'b0;
        while (!stat_seen) @(negedge clk);
        exp_bin = 0;
        exp_max = 0;
        exp_sum = 0;
        for (int i = 0; i < HIST_BINS; i++) begin
            if (m_hist[i] > exp_max) begin
                exp_max = m_hist[i];
                exp_bin = i;
            end
            exp_sum += i * m_hist[i];
        end
        check_eq("statistics latency", HIST_BINS + 1, rise_edge - req_edge);
        check_eq("statistics bin", exp_bin, stat_bin_o);
        check_eq("statistics sum", exp_sum, stat_sum_o);
    endtask

    initial begin
        in_data_i = '0;
        in_valid_i = 1'b0;
        out_ready_i = 1'b1;
        stat_req_i = 1'b0;
        seed = 32'hb6b6;
        cyc = 0;
        checks = 0;
        errors = 0;
        lat_mode = 1'b0;
        bp_mode = 1'b0;
        m_prev_link = '0;
        obs_prev_link = '0;
        tie_set = 0;
        tie_clr = 0;
        acc_cnt = 0;
        out_cnt = 0;
        prev_stall = 1'b0;
        held_data = '0;
        prev_stat_valid = 1'b0;
        stat_seen = 1'b0;
        req_edge = 0;
        rise_edge = 0;
        for (int s = 0; s < NUM_SEG; s++) begin
            m_prev_seg[s] = '0;
            m_prev_inv[s] = 1'b0;
        end
        for (int i = 0; i < HIST_BINS; i++) m_hist[i] = 0;

        wait (rst_n);
        @(negedge clk);
        check_eq("reset in_ready", 1, in_ready_o);
        check_eq("reset out_valid", 0, out_valid_o);
        check_eq("reset stat_valid", 0, stat_valid_o);
        check_eq("reset link", 0, link_o);

        // empty histogram, every bin ties at zero
        request_stats();

        // streaming without stalls, latency checked
        lat_mode = 1'b1;
        for (int i = 0; i < NUM_WORDS; i++) send_word($random(seed));
        drain();
        lat_mode = 1'b0;

        send_ties();
        drain();
        check_true(tie_set > 0 && tie_clr > 0, "tie cases with both flag states were not reached");

        bp_mode = 1'b1;
        for (int i = 0; i < NUM_WORDS; i++) send_word($random(seed));
        drain();
        bp_mode = 1'b0;
        @(negedge clk);

        // every coded word must have shown up on the link
        check_eq("link_coding pending", 0, exp_link_q.size());

        request_stats();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- files.f
hw/bi_pkg.sv
hw/bi_tx_stage.sv
hw/bi_seg_coder.sv
hw/bi_link_reg.sv
hw/bi_rx_stage.sv
hw/bi_transition_stats.sv
hw/bi_link_top.sv
tb/tb_clock_gen.sv
tb/bi_link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the bus-invert link testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -Wno-fatal -f files.f --top-module bi_link_tb -o bi_link_sim

./obj_dir/bi_link_sim | tee sim.log

if grep -q "^All tests passed!$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
